/* hdl/obj_pkg.sv */
package obj_pkg;

    // Sprite attribute table, 1024 words of 16 bits
    localparam int TBL_AW        = 10;
    localparam int WORDS_PER_OBJ = 8;

    // Word offsets inside one sprite entry
    localparam int W_TOP  = 0;
    localparam int W_XPOS = 1;
    localparam int W_BASE = 2;
    localparam int W_ATTR = 3;
    localparam int W_SIZE = 4;

    // Flag bits
    localparam int END_BIT   = 15;
    localparam int HFLIP_BIT = 8;

    // Draw command fields
    localparam int ROM_AW   = 20;
    localparam int PAL_W    = 8;
    localparam int WIDTH_W  = 4;
    localparam int HEIGHT_W = 8;

    // Scanner FSM
    typedef enum logic [2:0] {
        S_IDLE, S_READ_ATTR, S_TEST, S_ISSUE, S_WAIT_DRAW, S_DONE
    } scan_state_e;

    // Drawer FSM
    typedef enum logic [1:0] {
        D_IDLE, D_REQ, D_WAIT_OK, D_WRITE_PIX
    } draw_state_e;

endpackage

/* hdl/video_pkg.sv */
package video_pkg;

    // Line and pixel positions
    localparam int POS_W    = 9;
    localparam int LB_DEPTH = 1 << POS_W;

    // Pens, pen 0 never reaches the line buffer
    localparam int PEN_W = 4;
    localparam logic [PEN_W-1:0] TRANSP_PEN = '0;

    // Line buffer word is palette over pen
    localparam int PXL_W = 12;

    // Leftmost pixel sits in the top nibble of a ROM word
    localparam int PIX_PER_WORD = 4;

endpackage

/* hdl/obj_table_ram.sv */
`timescale 1ns/1ps

module obj_table_ram (
    input  logic                       clk,
    input  logic                       en,
    input  logic                       we,
    input  logic [1:0]                 be,
    input  logic [obj_pkg::TBL_AW-1:0] addr,
    input  logic [15:0]                din,
    output logic [15:0]                dout
);

    logic [15:0] mem [0:(1 << obj_pkg::TBL_AW)-1];

    // One access per cycle, read data one clock later
    always_ff @(posedge clk) begin
        if (en) begin
            // Low byte
            if (we && be[0]) begin
                mem[addr][7:0] <= din[7:0];
            end
            // High byte
            if (we && be[1]) begin
                mem[addr][15:8] <= din[15:8];
            end
            // Old contents on a write cycle
            dout <= mem[addr];
        end
    end

endmodule

/* hdl/obj_table_arb.sv */
`timescale 1ns/1ps

module obj_table_arb (
    input  logic                       clk,
    input  logic                       rst,
    // CPU side
    input  logic                       cpu_obj_cs,
    input  logic                       cpu_we,
    input  logic [obj_pkg::TBL_AW-1:0] cpu_addr,
    input  logic [15:0]                cpu_dout,
    input  logic [1:0]                 dsn,
    output logic [15:0]                cpu_din,
    // Scanner side
    input  logic                       tbl_rd,
    input  logic [obj_pkg::TBL_AW-1:0] tbl_addr,
    output logic                       tbl_ok,
    output logic [15:0]                tbl_dout,
    // RAM side
    output logic                       ram_en,
    output logic                       ram_we,
    output logic [1:0]                 ram_be,
    output logic [obj_pkg::TBL_AW-1:0] ram_addr,
    output logic [15:0]                ram_din,
    input  logic [15:0]                ram_dout
);

    // Set when the CPU owned last cycle's access
    logic cpu_owner;

    // CPU has absolute priority
    assign tbl_ok   = !cpu_obj_cs;
    assign ram_en   = cpu_obj_cs || tbl_rd;
    assign ram_we   = cpu_obj_cs && cpu_we;
    assign ram_addr = cpu_obj_cs ? cpu_addr : tbl_addr;
    assign ram_din  = cpu_dout;

    // Active low byte strobes to byte enables
    assign ram_be = ~dsn;

    always_ff @(posedge clk) begin
        if (rst) begin
            cpu_owner <= 1'b0;
        end else begin
            cpu_owner <= cpu_obj_cs;
        end
    end

    // Steer read data to whoever issued the address
    assign cpu_din  = cpu_owner ? ram_dout : '0;
    assign tbl_dout = cpu_owner ? '0 : ram_dout;

endmodule

/* hdl/obj_scan.sv */
`timescale 1ns/1ps

module obj_scan #(
    parameter int NUM_OBJ = 128
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         hstart,
    input  logic [video_pkg::POS_W-1:0]  vrender,
    // Table read port
    output logic                         tbl_rd,
    output logic [obj_pkg::TBL_AW-1:0]   tbl_addr,
    input  logic                         tbl_ok,
    input  logic [15:0]                  tbl_dout,
    // Draw command
    output logic                         dr_start,
    output logic [video_pkg::POS_W-1:0]  dr_xpos,
    output logic [obj_pkg::ROM_AW-1:0]   dr_addr,
    output logic [obj_pkg::WIDTH_W-1:0]  dr_width,
    output logic [obj_pkg::PAL_W-1:0]    dr_pal,
    output logic                         dr_hflip,
    input  logic                         dr_busy
);

    localparam int WD_W  = $clog2(obj_pkg::WORDS_PER_OBJ);
    localparam int IDX_W = obj_pkg::TBL_AW - WD_W;

    obj_pkg::scan_state_e state;

    logic [IDX_W-1:0]              obj_idx;
    logic [WD_W-1:0]               rd_word;
    logic [WD_W-1:0]               pend_word;
    logic                          pend;
    logic [video_pkg::POS_W-1:0]   line;
    logic [video_pkg::POS_W-1:0]   top;
    logic [video_pkg::POS_W-1:0]   xpos;
    logic [video_pkg::POS_W-1:0]   row;
    logic [15:0]                   base;
    logic [obj_pkg::PAL_W-1:0]     pal;
    logic                          hflip;
    logic [obj_pkg::WIDTH_W-1:0]   width;
    logic [obj_pkg::HEIGHT_W-1:0]  height;
    logic [obj_pkg::ROM_AW-1:0]    row_off;
    logic                          visible;
    logic                          advance;

    // Words 0 to 4 go out back to back, address held until taken
    assign tbl_rd   = state == obj_pkg::S_READ_ATTR && int'(rd_word) <= obj_pkg::W_SIZE;
    assign tbl_addr = {obj_idx, rd_word};

    // Row inside the sprite, wraps at 512
    assign row     = line - top;
    assign visible = row < height;
    assign row_off = row * width;

    // Move on once the sprite is skipped or fully drawn
    assign advance = (state == obj_pkg::S_TEST && !visible) ||
                     (state == obj_pkg::S_WAIT_DRAW && !dr_start && !dr_busy);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= obj_pkg::S_IDLE;
            pend     <= 1'b0;
            dr_start <= 1'b0;
            obj_idx  <= '0;
            rd_word  <= '0;
        end else begin
            dr_start <= 1'b0;
            pend     <= tbl_rd && tbl_ok;
            if (hstart) begin
                // New line, any scan in progress is dropped
                state   <= obj_pkg::S_READ_ATTR;
                line    <= vrender + 1'b1;
                obj_idx <= '0;
                rd_word <= '0;
                pend    <= 1'b0;
            end else begin
                case (state)
                    obj_pkg::S_READ_ATTR: begin
                        if (tbl_rd && tbl_ok) begin
                            pend_word <= rd_word;
                            rd_word   <= rd_word + 1'b1;
                        end
                        // Data of the word taken last cycle
                        if (pend) begin
                            case (int'(pend_word))
                                obj_pkg::W_TOP: begin
                                    top <= tbl_dout[video_pkg::POS_W-1:0];
                                    if (tbl_dout[obj_pkg::END_BIT]) begin
                                        state <= obj_pkg::S_DONE;
                                    end
                                end
                                obj_pkg::W_XPOS: xpos <= tbl_dout[video_pkg::POS_W-1:0];
                                obj_pkg::W_BASE: base <= tbl_dout;
                                obj_pkg::W_ATTR: begin
                                    pal   <= tbl_dout[obj_pkg::PAL_W-1:0];
                                    hflip <= tbl_dout[obj_pkg::HFLIP_BIT];
                                end
                                obj_pkg::W_SIZE: begin
                                    width  <= tbl_dout[obj_pkg::WIDTH_W-1:0];
                                    height <= tbl_dout[15 -: obj_pkg::HEIGHT_W];
                                    state  <= obj_pkg::S_TEST;
                                end
                                default: ;
                            endcase
                        end
                    end
                    obj_pkg::S_TEST: begin
                        if (visible) begin
                            dr_xpos  <= xpos;
                            dr_addr  <= row_off + base;
                            dr_width <= width;
                            dr_pal   <= pal;
                            dr_hflip <= hflip;
                            state    <= obj_pkg::S_ISSUE;
                        end
                    end
                    obj_pkg::S_ISSUE: begin
                        if (!dr_busy) begin
                            dr_start <= 1'b1;
                            state    <= obj_pkg::S_WAIT_DRAW;
                        end
                    end
                    default: ;
                endcase
                if (advance) begin
                    if (int'(obj_idx) == NUM_OBJ - 1) begin
                        state <= obj_pkg::S_DONE;
                    end else begin
                        obj_idx <= obj_idx + 1'b1;
                        rd_word <= '0;
                        state   <= obj_pkg::S_READ_ATTR;
                    end
                end
            end
        end
    end

endmodule

/* hdl/obj_draw.sv */
`timescale 1ns/1ps

module obj_draw (
    input  logic                         clk,
    input  logic                         rst,
    // Draw command
    input  logic                         dr_start,
    input  logic [video_pkg::POS_W-1:0]  dr_xpos,
    input  logic [obj_pkg::ROM_AW-1:0]   dr_addr,
    input  logic [obj_pkg::WIDTH_W-1:0]  dr_width,
    input  logic [obj_pkg::PAL_W-1:0]    dr_pal,
    input  logic                         dr_hflip,
    output logic                         dr_busy,
    // Graphics ROM
    output logic                         rom_cs,
    output logic [obj_pkg::ROM_AW-1:0]   rom_addr,
    input  logic                         rom_ok,
    input  logic [15:0]                  rom_data,
    // Line buffer write
    output logic                         buf_we,
    output logic [video_pkg::POS_W-1:0]  buf_addr,
    output logic [video_pkg::PXL_W-1:0]  buf_data
);

    localparam int PIX_W = $clog2(video_pkg::PIX_PER_WORD);

    obj_pkg::draw_state_e state;

    logic [video_pkg::POS_W-1:0]  xpos;
    logic [obj_pkg::PAL_W-1:0]    pal;
    logic                         hflip;
    logic [obj_pkg::WIDTH_W-1:0]  words_left;
    logic [15:0]                  pix_sr;
    logic [PIX_W-1:0]             pix_cnt;
    logic [video_pkg::PEN_W-1:0]  pen;

    // Mirrored rows take pixels from the right end of the word
    assign pen = hflip ? pix_sr[video_pkg::PEN_W-1:0] : pix_sr[15 -: video_pkg::PEN_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= obj_pkg::D_IDLE;
            dr_busy <= 1'b0;
            rom_cs  <= 1'b0;
            buf_we  <= 1'b0;
        end else begin
            buf_we <= 1'b0;
            case (state)
                obj_pkg::D_IDLE: begin
                    // Zero width draws nothing
                    if (dr_start && dr_width != '0) begin
                        xpos       <= dr_xpos;
                        pal        <= dr_pal;
                        hflip      <= dr_hflip;
                        words_left <= dr_width;
                        // Mirrored rows start with the last word
                        rom_addr <= dr_hflip ? dr_addr + dr_width - 1'b1 : dr_addr;
                        dr_busy  <= 1'b1;
                        state    <= obj_pkg::D_REQ;
                    end
                end
                obj_pkg::D_REQ: begin
                    rom_cs <= 1'b1;
                    state  <= obj_pkg::D_WAIT_OK;
                end
                obj_pkg::D_WAIT_OK: begin
                    // Latency set by the ROM side
                    if (rom_ok) begin
                        rom_cs  <= 1'b0;
                        pix_sr  <= rom_data;
                        pix_cnt <= '0;
                        state   <= obj_pkg::D_WRITE_PIX;
                    end
                end
                obj_pkg::D_WRITE_PIX: begin
                    // One pixel per cycle, pen 0 left out
                    buf_we   <= pen != video_pkg::TRANSP_PEN;
                    buf_addr <= xpos;
                    buf_data <= {pal, pen};
                    xpos     <= xpos + 1'b1;
                    pix_sr   <= hflip ? pix_sr >> video_pkg::PEN_W
                                      : pix_sr << video_pkg::PEN_W;
                    pix_cnt  <= pix_cnt + 1'b1;
                    if (int'(pix_cnt) == video_pkg::PIX_PER_WORD - 1) begin
                        if (words_left == 1) begin
                            dr_busy <= 1'b0;
                            state   <= obj_pkg::D_IDLE;
                        end else begin
                            words_left <= words_left - 1'b1;
                            rom_addr   <= hflip ? rom_addr - 1'b1 : rom_addr + 1'b1;
                            state      <= obj_pkg::D_REQ;
                        end
                    end
                end
                default: state <= obj_pkg::D_IDLE;
            endcase
        end
    end

endmodule

/* hdl/obj_line_buffer.sv */
`timescale 1ns/1ps

module obj_line_buffer #(
    parameter int PXL_DLY = 0
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         LHBL,
    input  logic                         pxl_cen,
    input  logic [video_pkg::POS_W-1:0]  wr_addr,
    input  logic [video_pkg::PXL_W-1:0]  wr_data,
    input  logic                         we,
    output logic [video_pkg::PXL_W-1:0]  pxl
);

    localparam logic [video_pkg::POS_W-1:0] DLY = PXL_DLY[video_pkg::POS_W-1:0];

    logic [video_pkg::PXL_W-1:0] half0 [0:video_pkg::LB_DEPTH-1];
    logic [video_pkg::PXL_W-1:0] half1 [0:video_pkg::LB_DEPTH-1];

    // bank picks the half being drawn, the other one plays out
    logic                         bank;
    logic                         lhbl_l;
    logic [video_pkg::POS_W-1:0]  rd_pos;
    logic                         rd_en;

    assign rd_en = LHBL && pxl_cen;

    always_ff @(posedge clk) begin
        if (rst) begin
            bank   <= 1'b0;
            lhbl_l <= 1'b0;
            rd_pos <= '0;
        end else begin
            lhbl_l <= LHBL;
            if (lhbl_l && !LHBL) begin
                // Swap halves, start PXL_DLY positions before 0
                bank   <= ~bank;
                rd_pos <= -DLY;
            end else if (rd_en) begin
                rd_pos <= rd_pos + 1'b1;
            end
        end
    end

    // One write per half per cycle, drawer or erase
    always_ff @(posedge clk) begin
        if (bank) begin
            if (we) half1[wr_addr] <= wr_data;
            if (rd_en) half0[rd_pos] <= '0;
        end else begin
            if (we) half0[wr_addr] <= wr_data;
            if (rd_en) half1[rd_pos] <= '0;
        end
    end

    // Old value goes out while the entry is cleared
    always_ff @(posedge clk) begin
        if (rst) begin
            pxl <= '0;
        end else if (rd_en) begin
            pxl <= bank ? half0[rd_pos] : half1[rd_pos];
        end
    end

endmodule

/* hdl/obj_engine.sv */
`timescale 1ns/1ps

module obj_engine #(
    parameter int PXL_DLY = 0,
    parameter int NUM_OBJ = 128
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         pxl_cen,
    // CPU
    input  logic                         cpu_obj_cs,
    input  logic                         cpu_we,
    input  logic [obj_pkg::TBL_AW-1:0]   cpu_addr,
    input  logic [15:0]                  cpu_dout,
    input  logic [1:0]                   dsn,
    output logic [15:0]                  cpu_din,
    // Graphics ROM
    output logic                         rom_cs,
    output logic [obj_pkg::ROM_AW-1:0]   rom_addr,
    input  logic                         rom_ok,
    input  logic [15:0]                  rom_data,
    // Video timing
    input  logic                         hstart,
    input  logic                         LHBL,
    input  logic [video_pkg::POS_W-1:0]  vrender,
    output logic [video_pkg::PXL_W-1:0]  pxl
);

    // Table access
    logic                         tbl_rd;
    logic                         tbl_ok;
    logic [obj_pkg::TBL_AW-1:0]   tbl_addr;
    logic [15:0]                  tbl_dout;
    logic                         ram_en;
    logic                         ram_we;
    logic [1:0]                   ram_be;
    logic [obj_pkg::TBL_AW-1:0]   ram_addr;
    logic [15:0]                  ram_din;
    logic [15:0]                  ram_dout;

    // Draw commands
    logic                         dr_start;
    logic                         dr_busy;
    logic [video_pkg::POS_W-1:0]  dr_xpos;
    logic [obj_pkg::ROM_AW-1:0]   dr_addr;
    logic [obj_pkg::WIDTH_W-1:0]  dr_width;
    logic [obj_pkg::PAL_W-1:0]    dr_pal;
    logic                         dr_hflip;

    // Line buffer writes
    logic                         buf_we;
    logic [video_pkg::POS_W-1:0]  buf_addr;
    logic [video_pkg::PXL_W-1:0]  buf_data;

    obj_table_arb u_arb (
        .clk        (clk),
        .rst        (rst),
        .cpu_obj_cs (cpu_obj_cs),
        .cpu_we     (cpu_we),
        .cpu_addr   (cpu_addr),
        .cpu_dout   (cpu_dout),
        .dsn        (dsn),
        .cpu_din    (cpu_din),
        .tbl_rd     (tbl_rd),
        .tbl_addr   (tbl_addr),
        .tbl_ok     (tbl_ok),
        .tbl_dout   (tbl_dout),
        .ram_en     (ram_en),
        .ram_we     (ram_we),
        .ram_be     (ram_be),
        .ram_addr   (ram_addr),
        .ram_din    (ram_din),
        .ram_dout   (ram_dout)
    );

    obj_table_ram u_ram (
        .clk  (clk),
        .en   (ram_en),
        .we   (ram_we),
        .be   (ram_be),
        .addr (ram_addr),
        .din  (ram_din),
        .dout (ram_dout)
    );

    obj_scan #(
        .NUM_OBJ (NUM_OBJ)
    ) u_scan (
        .clk      (clk),
        .rst      (rst),
        .hstart   (hstart),
        .vrender  (vrender),
        .tbl_rd   (tbl_rd),
        .tbl_addr (tbl_addr),
        .tbl_ok   (tbl_ok),
        .tbl_dout (tbl_dout),
        .dr_start (dr_start),
        .dr_xpos  (dr_xpos),
        .dr_addr  (dr_addr),
        .dr_width (dr_width),
        .dr_pal   (dr_pal),
        .dr_hflip (dr_hflip),
        .dr_busy  (dr_busy)
    );

    obj_draw u_draw (
        .clk      (clk),
        .rst      (rst),
        .dr_start (dr_start),
        .dr_xpos  (dr_xpos),
        .dr_addr  (dr_addr),
        .dr_width (dr_width),
        .dr_pal   (dr_pal),
        .dr_hflip (dr_hflip),
        .dr_busy  (dr_busy),
        .rom_cs   (rom_cs),
        .rom_addr (rom_addr),
        .rom_ok   (rom_ok),
        .rom_data (rom_data),
        .buf_we   (buf_we),
        .buf_addr (buf_addr),
        .buf_data (buf_data)
    );

    obj_line_buffer #(
        .PXL_DLY (PXL_DLY)
    ) u_line (
        .clk     (clk),
        .rst     (rst),
        .LHBL    (LHBL),
        .pxl_cen (pxl_cen),
        .wr_addr (buf_addr),
        .wr_data (buf_data),
        .we      (buf_we),
        .pxl     (pxl)
    );

endmodule

/* sim/tb_rom_model.sv */
`timescale 1ns/1ps

module tb_rom_model (
    input  logic        clk,
    input  logic        rst,
    input  logic        cs,
    input  logic [19:0] addr,
    output logic        ok,
    output logic [15:0] data
);

    integer     lat_seed;
    integer     lat_rnd;
    logic [1:0] wait_cnt;

    // Word contents, fixed per address
    function automatic logic [15:0] word_at(input logic [19:0] a);
        integer s;
        integer r;
        s = 32'hdbcf_994a ^ (a * 32'h9e37) ^ {a, 12'h5a5};
        r = $random(s);
        return r[15:0];
    endfunction

    initial lat_seed = 32'hdbcf_994a;

    always @(posedge clk) begin
        if (rst) begin
            ok       <= 1'b0;
            data     <= '0;
            wait_cnt <= '0;
        end else begin
            ok <= 1'b0;
            if (!cs) begin
                // Pick the next latency, 1 to 4 cycles
                lat_rnd  = $random(lat_seed);
                wait_cnt <= lat_rnd[1:0];
            end else if (!ok) begin
                if (wait_cnt == 0) begin
                    ok   <= 1'b1;
                    data <= word_at(addr);
                end else begin
                    wait_cnt <= wait_cnt - 1'b1;
                end
            end
        end
    end

endmodule

/* sim/tb_obj_engine.sv */
`timescale 1ns/1ps

module tb_obj_engine;

    localparam int ACTIVE   = 400;
    localparam int NUM_OBJ  = 128;
    localparam int SCAN_MAX = 1500;

    logic        clk;
    logic        rst;
    logic        pxl_cen;
    logic        cpu_obj_cs;
    logic        cpu_we;
    logic [9:0]  cpu_addr;
    logic [15:0] cpu_dout;
    logic [1:0]  dsn;
    logic [15:0] cpu_din;
    logic        rom_cs;
    logic [19:0] rom_addr;
    logic        rom_ok;
    logic [15:0] rom_data;
    logic        hstart;
    logic        LHBL;
    logic [8:0]  vrender;
    logic [11:0] pxl;

    // Testbench copy of the sprite table
    logic [15:0] tbl_copy [0:1023];

    // Expected lines trail the drawn ones by two lines through the line buffer
    logic [11:0] exp_mid  [0:ACTIVE-1];
    logic [11:0] exp_show [0:ACTIVE-1];
    logic        valid_mid;
    logic        valid_show;
    string       name_mid;
    string       name_show;
    int          line_mid;
    int          line_show;
    int          col;
    int          err_cnt;

    obj_engine #(
        .PXL_DLY (0),
        .NUM_OBJ (NUM_OBJ)
    ) u_dut (
        .clk        (clk),
        .rst        (rst),
        .pxl_cen    (pxl_cen),
        .cpu_obj_cs (cpu_obj_cs),
        .cpu_we     (cpu_we),
        .cpu_addr   (cpu_addr),
        .cpu_dout   (cpu_dout),
        .dsn        (dsn),
        .cpu_din    (cpu_din),
        .rom_cs     (rom_cs),
        .rom_addr   (rom_addr),
        .rom_ok     (rom_ok),
        .rom_data   (rom_data),
        .hstart     (hstart),
        .LHBL       (LHBL),
        .vrender    (vrender),
        .pxl        (pxl)
    );

    tb_rom_model u_rom (
        .clk  (clk),
        .rst  (rst),
        .cs   (rom_cs),
        .addr (rom_addr),
        .ok   (rom_ok),
        .data (rom_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_fail(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // Byte-masked write that updates the copy the same way
    task automatic cpu_write(input logic [9:0] a, input logic [15:0] d, input logic [1:0] n);
        cpu_obj_cs = 1'b1;
        cpu_we     = 1'b1;
        cpu_addr   = a;
        cpu_dout   = d;
        dsn        = n;
        @(negedge clk);
        cpu_obj_cs = 1'b0;
        cpu_we     = 1'b0;
        dsn        = 2'b11;
        if (!n[0]) tbl_copy[a][7:0] = d[7:0];
        if (!n[1]) tbl_copy[a][15:8] = d[15:8];
    endtask

    // Back-to-back reads with data checked the cycle after each address
    task automatic cpu_read_burst(input logic [9:0] a, input int n, input string tname);
        int k;
        for (k = 0; k < n; k++) begin
            cpu_obj_cs = 1'b1;
            cpu_we     = 1'b0;
            cpu_addr   = a + k;
            @(negedge clk);
            assert (cpu_din === tbl_copy[a + k]) else begin
                $display("[FAIL] %s addr %h expected %h actual %h",
                         tname, a + k, tbl_copy[a + k], cpu_din);
                stop_fail("table read returned the wrong word");
            end
        end
        cpu_obj_cs = 1'b0;
    endtask

    task automatic set_sprite(input int idx, input logic [15:0] w0, input logic [15:0] w1,
                              input logic [15:0] w2, input logic [15:0] w3,
                              input logic [15:0] w4);
        cpu_write(idx * 8 + 0, w0, 2'b00);
        cpu_write(idx * 8 + 1, w1, 2'b00);
        cpu_write(idx * 8 + 2, w2, 2'b00);
        cpu_write(idx * 8 + 3, w3, 2'b00);
        cpu_write(idx * 8 + 4, w4, 2'b00);
    endtask

    // Expected line from the table copy and ROM pattern
    function automatic void compute_line(input logic [8:0] tgt);
        int          i;
        int          wd;
        int          p;
        int          k;
        int          width;
        int          ra;
        logic [15:0] w0;
        logic [15:0] w1;
        logic [15:0] w2;
        logic [15:0] w3;
        logic [15:0] w4;
        logic [15:0] word;
        logic [8:0]  row;
        logic [8:0]  x;
        logic [3:0]  pen;
        for (k = 0; k < ACTIVE; k++) exp_mid[k] = '0;
        for (i = 0; i < NUM_OBJ; i++) begin
            w0 = tbl_copy[i * 8];
            w1 = tbl_copy[i * 8 + 1];
            w2 = tbl_copy[i * 8 + 2];
            w3 = tbl_copy[i * 8 + 3];
            w4 = tbl_copy[i * 8 + 4];
            if (w0[15]) break;
            row   = tgt - w0[8:0];
            width = w4[3:0];
            if (row < w4[15:8]) begin
                ra = int'(w2) + int'(row) * width;
                for (wd = 0; wd < width; wd++) begin
                    word = u_rom.word_at(ra + wd);
                    for (p = 0; p < 4; p++) begin
                        pen = word[15 - 4 * p -: 4];
                        k   = wd * 4 + p;
                        // Mirror about the sprite row centre
                        x = w3[8] ? w1[8:0] + (width * 4 - 1 - k) : w1[8:0] + k;
                        if (pen != 4'd0 && x < ACTIVE) exp_mid[x] = {w3[7:0], pen};
                    end
                end
            end
        end
    endfunction

    function automatic string name_for(input int tgt);
        if (tgt >= 20 && tgt < 28) return "single_and_end_flag";
        if (tgt >= 40 && tgt < 43) return "overlap_backpressure";
        if (tgt >= 60 && tgt < 62) return "hflip";
        return "empty_line";
    endfunction

    // Scan done and drawer idle as seen through the hierarchy
    task automatic wait_scan_done();
        int t;
        t = 0;
        while (!(u_dut.u_scan.state == obj_pkg::S_DONE && !u_dut.dr_busy)) begin
            @(negedge clk);
            t++;
            if (t > SCAN_MAX) stop_fail("sprite scan did not finish within the blanking period");
        end
    endtask

    // Pixel checker samples one clock after each read strobe
    initial begin
        forever begin
            @(posedge clk);
            if (LHBL && pxl_cen) begin
                @(negedge clk);
                if (valid_show) begin
                    assert (pxl === exp_show[col]) else begin
                        err_cnt++;
                        $display("[FAIL] %s line %0d x %0d expected %h actual %h",
                                 name_show, line_show, col, exp_show[col], pxl);
                        stop_fail("pixel mismatch on playback");
                    end
                end
                col++;
            end
        end
    end

    initial begin
        repeat (150000) @(posedge clk);
        stop_fail("simulation ran past its cycle limit");
    end

    initial begin
        int a;
        int v;
        int c;
        rst = 1'b1;
        pxl_cen = 1'b0;
        cpu_obj_cs = 1'b0;
        cpu_we = 1'b0;
        cpu_addr = '0;
        cpu_dout = '0;
        dsn = 2'b11;
        hstart = 1'b0;
        LHBL = 1'b0;
        vrender = '0;
        valid_mid = 1'b0;
        valid_show = 1'b0;
        col = 0;
        err_cnt = 0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // Clear the table
        for (a = 0; a < 1024; a++) cpu_write(a, 16'h0000, 2'b00);

        // Byte lanes on a spare word
        cpu_write(10'h3f5, 16'h1234, 2'b00);
        cpu_write(10'h3f5, 16'hab_cd, 2'b10);
        cpu_write(10'h3f5, 16'hef_99, 2'b01);
        cpu_write(10'h3f5, 16'h5555, 2'b11);
        cpu_read_burst(10'h3f5, 1, "cpu_readback");
        cpu_read_burst(10'h3f0, 8, "cpu_readback");

        // top, xpos, base, attr, size
        set_sprite(0, 16'd20, 16'd10,  16'h0100, 16'h0011, 16'h0402);
        set_sprite(1, 16'd40, 16'd100, 16'h0200, 16'h0022, 16'h0303);
        set_sprite(2, 16'd40, 16'd104, 16'h0300, 16'h0033, 16'h0304);
        set_sprite(3, 16'd60, 16'd200, 16'h0400, 16'h0144, 16'h0203);
        // End of list hides the sprite after it
        cpu_write(4 * 8, 16'h8000, 2'b00);
        set_sprite(5, 16'd20, 16'd300, 16'h0500, 16'h0055, 16'h0804);
        cpu_read_burst(0, 48, "cpu_readback");

        for (v = 16; v < 64; v++) begin
            vrender = v;
            col = 0;
            LHBL = 1'b1;
            for (c = 0; c < 2 * ACTIVE; c++) begin
                pxl_cen = (c % 2) == 0;
                @(negedge clk);
            end
            LHBL = 1'b0;
            pxl_cen = 1'b0;
            @(negedge clk);
            hstart = 1'b1;
            @(negedge clk);
            hstart = 1'b0;
            // Shift the expectation pipeline
            exp_show = exp_mid;
            valid_show = valid_mid;
            name_show = name_mid;
            line_show = line_mid;
            compute_line(v + 1);
            valid_mid = 1'b1;
            name_mid = name_for(v + 1);
            line_mid = v + 1;
            // CPU takes the table while the words of sprite 1 are in flight
            if (v == 40) begin
                repeat (10) @(negedge clk);
                cpu_read_burst(0, 40, "overlap_backpressure");
            end
            wait_scan_done();
            repeat (100) @(negedge clk);
        end

        if (err_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
hdl/obj_pkg.sv
hdl/video_pkg.sv
hdl/obj_table_ram.sv
hdl/obj_table_arb.sv
hdl/obj_scan.sv
hdl/obj_draw.sv
hdl/obj_line_buffer.sv
hdl/obj_engine.sv
sim/tb_rom_model.sv
sim/tb_obj_engine.sv

/* Bender.yml */
package:
  name: obj_engine

sources:
  - target: any(rtl, test)
    files:
      - hdl/obj_pkg.sv
      - hdl/video_pkg.sv
      - hdl/obj_table_ram.sv
      - hdl/obj_table_arb.sv
      - hdl/obj_scan.sv
      - hdl/obj_draw.sv
      - hdl/obj_line_buffer.sv
      - hdl/obj_engine.sv
  - target: test
    files:
      - sim/tb_rom_model.sv
      - sim/tb_obj_engine.sv
